/* bench/cache_tb.sv */
`timescale 1ns/100ps
`include "cache_consts.svh"

module cache_tb;
	import cache_pkg::*;

	// A few hundred cycles are needed, so this leaves a wide margin
	localparam int timeout_cycles = 2000;

	localparam logic [29:0] addr_a = {23'h012345, 3'd2, 2'd1, 2'd3};
	localparam logic [29:0] addr_a2 = {23'h012345, 3'd2, 2'd3, 2'd0};
	localparam logic [29:0] addr_b = {23'h000777, 3'd5, 2'd2, 2'd1};
	localparam logic [29:0] addr_c = {23'h054321, 3'd2, 2'd0, 2'd2};

	logic clk;
	logic reset;
	logic stall_en;
	logic cpu_req_valid;
	cpu_req_t cpu_req;
	logic cpu_req_ready;
	logic cpu_resp_valid;
	logic [`CPU_DATA_BITS-1:0] cpu_resp_data;
	logic mem_req_valid;
	mem_req_t mem_req;
	logic mem_req_ready;
	logic mem_wdata_valid;
	mem_wdata_t mem_wdata;
	logic mem_wdata_ready;
	logic mem_resp_valid;
	logic [`MEM_DATA_BITS-1:0] mem_resp_data;

	logic [`MEM_DATA_BITS-1:0] ref_mem [logic [`MEM_ADDR_BITS-1:0]];
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int cycles = 0;

	cache_top UUT (
		.clk(clk),
		.reset(reset),
		.cpu_req_valid(cpu_req_valid),
		.cpu_req(cpu_req),
		.cpu_req_ready(cpu_req_ready),
		.cpu_resp_valid(cpu_resp_valid),
		.cpu_resp_data(cpu_resp_data),
		.mem_req_valid(mem_req_valid),
		.mem_req(mem_req),
		.mem_req_ready(mem_req_ready),
		.mem_wdata_valid(mem_wdata_valid),
		.mem_wdata(mem_wdata),
		.mem_wdata_ready(mem_wdata_ready),
		.mem_resp_valid(mem_resp_valid),
		.mem_resp_data(mem_resp_data)
	);

	mem_model u_mem (
		.clk(clk),
		.stall_en(stall_en),
		.mem_req_valid(mem_req_valid),
		.mem_req(mem_req),
		.mem_req_ready(mem_req_ready),
		.mem_wdata_valid(mem_wdata_valid),
		.mem_wdata(mem_wdata),
		.mem_wdata_ready(mem_wdata_ready),
		.mem_resp_valid(mem_resp_valid),
		.mem_resp_data(mem_resp_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reference memory, same fill rule as the memory model
	function automatic logic [127:0] ref_beat(input logic [27:0] beat_addr);
		if (ref_mem.exists(beat_addr)) begin
			return ref_mem[beat_addr];
		end
		return {4{{4'h0, beat_addr}}};
	endfunction

	function automatic logic [31:0] ref_word(input logic [29:0] addr);
		logic [127:0] beat;
		beat = ref_beat(addr[29:2]);
		return beat[32*addr[1:0] +: 32];
	endfunction

	task automatic ref_write(input logic [29:0] addr, input logic [31:0] data,
		input logic [3:0] mask);
		logic [127:0] beat;
		beat = ref_beat(addr[29:2]);
		for (int i = 0; i < 4; i++) begin
			if (mask[i]) begin
				beat[32*addr[1:0] + 8*i +: 8] = data[8*i +: 8];
			end
		end
		ref_mem[addr[29:2]] = beat;
	endtask

	task automatic check_value(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		checks++;
		if (expected !== actual) begin
			$display("** Error: %s expected %0h got %0h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_count(input string what, input int expected, input int actual);
		checks++;
		if (expected != actual) begin
			$display("Expected %0d %s but counted %0d", expected, what, actual);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int base_errors);
		tests++;
		$display("Test %s finished with %0d errors", name, errors - base_errors);
	endtask

	// Called 1 ns after an edge, returns 1 ns after the accepting edge
	task automatic issue(input logic [29:0] addr, input logic [31:0] data,
		input logic [3:0] mask);
		cpu_req_valid = 1'b1;
		cpu_req.addr = addr;
		cpu_req.data = data;
		cpu_req.wmask = mask;
		@(posedge clk);
		while (!cpu_req_ready) begin
			@(posedge clk);
		end
		#1;
		cpu_req_valid = 1'b0;
	endtask

	task automatic do_read(input logic [29:0] addr, output logic [31:0] data,
		output int latency);
		issue(addr, 32'h0, 4'h0);
		latency = 0;
		do begin
			@(posedge clk);
			latency++;
		end while (!cpu_resp_valid);
		data = cpu_resp_data;
		#1;
	endtask

	task automatic do_write(input logic [29:0] addr, input logic [31:0] data,
		input logic [3:0] mask);
		issue(addr, data, mask);
		do begin
			@(posedge clk);
			check_value("cpu_resp_valid", 1'b0, cpu_resp_valid);
		end while (!cpu_req_ready);
		#1;
		ref_write(addr, data, mask);
	endtask

	task automatic check_write_port(input logic [29:0] addr, input logic [3:0] mask,
		input int writes);
		logic [15:0] lane_mask;
		lane_mask = 16'(mask) << (4 * addr[1:0]);
		check_count("memory write requests", writes + 1, u_mem.write_reqs);
		check_value("mem_req.addr", addr[29:2], u_mem.wr_addr);
		check_value("mem_wdata.mask", lane_mask, u_mem.last_wr_mask);
		// Memory beat after the masked write
		check_value("mem_wdata.data", ref_beat(addr[29:2]), u_mem.load_beat(addr[29:2]));
	endtask

	task automatic test_reset_values();
		int base_errors;
		base_errors = errors;
		check_value("cpu_req_ready", 1'b1, cpu_req_ready);
		check_value("cpu_resp_valid", 1'b0, cpu_resp_valid);
		check_value("mem_req_valid", 1'b0, mem_req_valid);
		check_value("mem_wdata_valid", 1'b0, mem_wdata_valid);
		report_test("reset values", base_errors);
	endtask

	task automatic test_read_miss();
		int base_errors;
		int reads;
		int latency;
		logic [31:0] data;
		base_errors = errors;
		reads = u_mem.read_reqs;
		do_read(addr_a, data, latency);
		check_count("memory read requests", reads + 1, u_mem.read_reqs);
		check_value("mem_req.addr", {addr_a[29:4], 2'b00}, u_mem.last_rd_addr);
		check_value("cpu_resp_data", ref_word(addr_a), data);
		report_test("read miss", base_errors);
	endtask

	task automatic test_read_hit();
		int base_errors;
		int reads;
		int latency;
		logic [31:0] data;
		base_errors = errors;
		reads = u_mem.read_reqs;
		do_read(addr_a2, data, latency);
		check_count("memory read requests", reads, u_mem.read_reqs);
		check_count("cycles from accept to response", 1, latency);
		check_value("cpu_resp_data", ref_word(addr_a2), data);
		report_test("read hit", base_errors);
	endtask

	task automatic test_write_through();
		int base_errors;
		int reads;
		int writes;
		int latency;
		logic [31:0] data;
		base_errors = errors;
		reads = u_mem.read_reqs;
		writes = u_mem.write_reqs;
		do_write(addr_b, $urandom(), 4'b1011);
		check_write_port(addr_b, 4'b1011, writes);
		// No allocate on a write miss, so this read fetches the updated beat
		do_read(addr_b, data, latency);
		check_count("memory read requests", reads + 1, u_mem.read_reqs);
		check_value("cpu_resp_data", ref_word(addr_b), data);
		report_test("write through", base_errors);
	endtask

	task automatic test_write_hit();
		int base_errors;
		int reads;
		int writes;
		int latency;
		logic [31:0] data;
		base_errors = errors;
		reads = u_mem.read_reqs;
		writes = u_mem.write_reqs;
		do_write(addr_a2, $urandom(), 4'b0110);
		check_write_port(addr_a2, 4'b0110, writes);
		do_read(addr_a2, data, latency);
		check_count("memory read requests", reads, u_mem.read_reqs);
		check_value("cpu_resp_data", ref_word(addr_a2), data);
		report_test("write hit", base_errors);
	endtask

	task automatic test_conflict();
		int base_errors;
		int reads;
		int latency;
		logic [31:0] data;
		base_errors = errors;
		reads = u_mem.read_reqs;
		do_read(addr_c, data, latency);
		check_value("cpu_resp_data", ref_word(addr_c), data);
		do_read(addr_a, data, latency);
		check_count("memory read requests", reads + 2, u_mem.read_reqs);
		check_value("mem_req.addr", {addr_a[29:4], 2'b00}, u_mem.last_rd_addr);
		check_value("cpu_resp_data", ref_word(addr_a), data);
		report_test("conflict", base_errors);
	endtask

	task automatic test_backpressure();
		int base_errors;
		int writes;
		int latency;
		logic [29:0] addr;
		logic [3:0] mask;
		logic [31:0] data;
		base_errors = errors;
		stall_en = 1'b1;
		repeat (16) begin
			// Two tags on two lines keeps hits, misses and conflicts mixed
			addr = {$urandom_range(1) ? addr_a[29:7] : addr_c[29:7],
				$urandom_range(1) ? 3'd2 : 3'd5, 4'($urandom())};
			if ($urandom_range(1) == 1) begin
				mask = 4'($urandom_range(15, 1));
				writes = u_mem.write_reqs;
				do_write(addr, $urandom(), mask);
				check_write_port(addr, mask, writes);
			end else begin
				do_read(addr, data, latency);
				check_value("cpu_resp_data", ref_word(addr), data);
			end
		end
		stall_en = 1'b0;
		report_test("back-pressure", base_errors);
	endtask

	initial begin
		void'($urandom(26));
		reset = 1'b1;
		stall_en = 1'b0;
		cpu_req_valid = 1'b0;
		cpu_req = '0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		test_reset_values();
		test_read_miss();
		test_read_hit();
		test_write_through();
		test_write_hit();
		test_conflict();
		test_backpressure();
		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		while (cycles < timeout_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("Run stopped after %0d cycles without finishing", cycles);
		$display("Simulation failed");
		$finish;
	end

endmodule

/* bench/mem_model.sv */
`timescale 1ns/100ps
`include "cache_consts.svh"

module mem_model (
	input logic clk,
	input logic stall_en,
	input logic mem_req_valid,
	input cache_pkg::mem_req_t mem_req,
	output logic mem_req_ready,
	input logic mem_wdata_valid,
	input cache_pkg::mem_wdata_t mem_wdata,
	output logic mem_wdata_ready,
	output logic mem_resp_valid,
	output logic [`MEM_DATA_BITS-1:0] mem_resp_data
);

	logic [`MEM_DATA_BITS-1:0] beats [logic [`MEM_ADDR_BITS-1:0]];
	logic [`MEM_ADDR_BITS-1:0] rd_addr;
	logic [`MEM_ADDR_BITS-1:0] last_rd_addr;
	logic [`MEM_ADDR_BITS-1:0] wr_addr;
	logic [`MEM_MASK_BITS-1:0] last_wr_mask;
	int rd_left = 0;
	int req_wait = 0;
	int wd_wait = 0;
	int read_reqs = 0;
	int write_reqs = 0;

	// Untouched beats hold their own address in every word lane
	function automatic logic [`MEM_DATA_BITS-1:0] load_beat(input logic [`MEM_ADDR_BITS-1:0] addr);
		if (beats.exists(addr)) begin
			return beats[addr];
		end
		return {4{{4'h0, addr}}};
	endfunction

	function automatic int stall_cycles();
		return stall_en ? $urandom_range(3) : 0;
	endfunction

	initial begin
		logic [`MEM_DATA_BITS-1:0] merged;
		mem_req_ready = 1'b1;
		mem_wdata_ready = 1'b1;
		mem_resp_valid = 1'b0;
		mem_resp_data = '0;
		forever begin
			@(posedge clk);
			if (mem_resp_valid) begin
				rd_left--;
				rd_addr++;
			end
			if (mem_req_valid && mem_req_ready) begin
				if (mem_req.rw) begin
					wr_addr = mem_req.addr;
					write_reqs++;
				end else begin
					rd_addr = mem_req.addr;
					last_rd_addr = mem_req.addr;
					rd_left = `BEATS_PER_LINE;
					read_reqs++;
				end
				req_wait = stall_cycles();
			end else if (mem_req_valid && req_wait > 0) begin
				req_wait--;
			end
			if (mem_wdata_valid && mem_wdata_ready) begin
				merged = load_beat(wr_addr);
				for (int b = 0; b < `MEM_MASK_BITS; b++) begin
					if (mem_wdata.mask[b]) begin
						merged[8*b +: 8] = mem_wdata.data[8*b +: 8];
					end
				end
				beats[wr_addr] = merged;
				last_wr_mask = mem_wdata.mask;
				wd_wait = stall_cycles();
			end else if (mem_wdata_valid && wd_wait > 0) begin
				wd_wait--;
			end
			#1;
			mem_req_ready = req_wait == 0;
			mem_wdata_ready = wd_wait == 0;
			// Beats stream back to back in order 0 to 3
			mem_resp_valid = rd_left > 0;
			mem_resp_data = rd_left > 0 ? load_beat(rd_addr) : '0;
		end
	end

endmodule

/* cache/cache_ctrl.sv */
`timescale 1ns/100ps

module cache_ctrl (
	input logic clk,
	input logic reset,
	input logic cpu_req_valid,
	output logic cpu_req_ready,
	input logic hit,
	input logic req_write,
	input logic refill_last,
	output logic mem_req_valid,
	input logic mem_req_ready,
	output logic mem_wdata_valid,
	input logic mem_wdata_ready,
	output logic refill_active,
	output logic cpu_resp_valid,
	output cache_pkg::store_ctl_t store_ctl
);

	typedef enum logic [2:0] {
		idle,
		lookup,
		miss_req,
		refill,
		refill_done,
		write_req,
		write_data
	} state_t;

	state_t state;
	state_t state_next;
	logic read_hit;
	logic accept;

	// Tag compare is valid in lookup, one cycle after accept
	assign read_hit = state == lookup && !req_write && hit;

	assign cpu_req_ready = state == idle || read_hit || state == refill_done;
	assign accept = cpu_req_valid && cpu_req_ready;

	assign cpu_resp_valid = read_hit || state == refill_done;
	assign mem_req_valid = state == miss_req || state == write_req;
	assign mem_wdata_valid = state == write_data;
	assign refill_active = state == refill;

	always_comb begin
		store_ctl.accept = accept;
		store_ctl.tag_fill = state == lookup && !req_write && !hit;
		// Held over the whole refill, the slot only moves when a beat lands
		store_ctl.refill_beat = state == refill;
		store_ctl.cpu_write = state == write_data && mem_wdata_ready;
		store_ctl.resp_refill = state == refill_done;
	end

	always_comb begin
		state_next = state;
		case (state)
			idle, refill_done: begin
				state_next = accept ? lookup : idle;
			end
			lookup: begin
				if (req_write) begin
					state_next = write_req;
				end else if (hit) begin
					state_next = accept ? lookup : idle;
				end else begin
					state_next = miss_req;
				end
			end
			miss_req: begin
				if (mem_req_ready) begin
					state_next = refill;
				end
			end
			refill: begin
				if (refill_last) begin
					state_next = refill_done;
				end
			end
			write_req: begin
				if (mem_req_ready) begin
					state_next = write_data;
				end
			end
			write_data: begin
				if (mem_wdata_ready) begin
					state_next = idle;
				end
			end
			default: begin
				state_next = idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
		end else begin
			state <= state_next;
		end
	end

	mem_req_held: assert property (@(posedge clk) disable iff (reset)
		mem_req_valid && !mem_req_ready |=> mem_req_valid);

endmodule

/* cache/cache_store.sv */
`timescale 1ns/100ps
`include "cache_consts.svh"

module cache_store (
	input logic clk,
	input logic reset,
	input cache_pkg::cpu_req_t cpu_req,
	input cache_pkg::store_ctl_t store_ctl,
	input logic [`BEAT_BITS-1:0] beat,
	input logic [`MEM_DATA_BITS-1:0] mem_resp_data,
	output logic hit,
	output logic req_write,
	output cache_pkg::mem_req_t mem_req,
	output cache_pkg::mem_wdata_t mem_wdata,
	output logic [`CPU_DATA_BITS-1:0] cpu_resp_data
);
	import cache_pkg::*;

	cpu_req_t req_q;
	cache_addr_t rd_addr;
	logic [`TAG_BITS-1:0] tag_arr [0:(1 << `INDEX_BITS)-1];
	logic [(1 << `INDEX_BITS)-1:0] line_valid;
	logic [`MEM_DATA_BITS-1:0] data_arr [0:(1 << (`INDEX_BITS + `BEAT_BITS))-1];
	logic [`TAG_BITS-1:0] tag_rd;
	logic valid_rd;
	logic [`MEM_DATA_BITS-1:0] data_rd;
	logic [`INDEX_BITS+`BEAT_BITS-1:0] wr_slot;
	logic [`MEM_DATA_BITS-1:0] align_beat;
	logic [`CPU_DATA_BITS-1:0] rd_word;
	logic [`CPU_DATA_BITS-1:0] crit_word;
	logic [`MEM_DATA_BITS-1:0] lane_data;
	logic [`MEM_MASK_BITS-1:0] lane_mask;

	always_ff @(posedge clk) begin
		if (store_ctl.accept) begin
			req_q <= cpu_req;
		end
	end

	// New address on accept, else keep reading the held request
	assign rd_addr = store_ctl.accept ? cpu_req.addr : req_q.addr;

	always_ff @(posedge clk) begin
		tag_rd <= tag_arr[rd_addr.cache.index];
		if (store_ctl.tag_fill) begin
			tag_arr[req_q.addr.cache.index] <= req_q.addr.cache.tag;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			line_valid <= '0;
			valid_rd <= 1'b0;
		end else begin
			valid_rd <= line_valid[rd_addr.cache.index];
			if (store_ctl.tag_fill) begin
				line_valid[req_q.addr.cache.index] <= 1'b1;
			end
		end
	end

	assign hit = valid_rd && tag_rd == req_q.addr.cache.tag;
	assign req_write = |req_q.wmask;

	assign wr_slot = store_ctl.refill_beat ? {req_q.addr.cache.index, beat} :
		{req_q.addr.cache.index, req_q.addr.cache.beat};

	always_ff @(posedge clk) begin
		data_rd <= data_arr[{rd_addr.cache.index, rd_addr.cache.beat}];
		if (store_ctl.refill_beat) begin
			data_arr[wr_slot] <= mem_resp_data;
		end else if (store_ctl.cpu_write && hit) begin
			// Byte merge on write hit
			for (int b = 0; b < `MEM_MASK_BITS; b++) begin
				if (lane_mask[b]) begin
					data_arr[wr_slot][8*b +: 8] <= lane_data[8*b +: 8];
				end
			end
		end
	end

	assign align_beat = store_ctl.refill_beat ? mem_resp_data : data_rd;

	lane_align u_lane_align (
		.word(req_q.addr.cache.word),
		.wr_data(req_q.data),
		.wr_mask(req_q.wmask),
		.rd_beat(align_beat),
		.rd_word(rd_word),
		.lane_data(lane_data),
		.lane_mask(lane_mask)
	);

	// Critical word
	always_ff @(posedge clk) begin
		if (store_ctl.refill_beat && beat == req_q.addr.cache.beat) begin
			crit_word <= rd_word;
		end
	end

	assign cpu_resp_data = store_ctl.resp_refill ? crit_word : rd_word;

	// Reads fetch the whole line from beat 0
	always_comb begin
		mem_req.rw = req_write;
		if (req_write) begin
			mem_req.addr = req_q.addr.mem.beat_addr;
		end else begin
			mem_req.addr = {req_q.addr.cache.tag, req_q.addr.cache.index, {`BEAT_BITS{1'b0}}};
		end
		mem_wdata.data = lane_data;
		mem_wdata.mask = lane_mask;
	end

	no_refill_cpu_write: assert property (@(posedge clk) disable iff (reset)
		!(store_ctl.refill_beat && store_ctl.cpu_write));

endmodule

/* cache/cache_top.sv */
`timescale 1ns/100ps
`include "cache_consts.svh"

module cache_top (
	input logic clk,
	input logic reset,

	input logic cpu_req_valid,
	input cache_pkg::cpu_req_t cpu_req,
	output logic cpu_req_ready,
	output logic cpu_resp_valid,
	output logic [`CPU_DATA_BITS-1:0] cpu_resp_data,

	output logic mem_req_valid,
	output cache_pkg::mem_req_t mem_req,
	input logic mem_req_ready,
	output logic mem_wdata_valid,
	output cache_pkg::mem_wdata_t mem_wdata,
	input logic mem_wdata_ready,
	input logic mem_resp_valid,
	input logic [`MEM_DATA_BITS-1:0] mem_resp_data
);
	import cache_pkg::*;

	store_ctl_t store_ctl;
	logic hit;
	logic req_write;
	logic refill_active;
	logic refill_last;
	logic [`BEAT_BITS-1:0] beat;

	cache_ctrl u_ctrl (
		.clk(clk),
		.reset(reset),
		.cpu_req_valid(cpu_req_valid),
		.cpu_req_ready(cpu_req_ready),
		.hit(hit),
		.req_write(req_write),
		.refill_last(refill_last),
		.mem_req_valid(mem_req_valid),
		.mem_req_ready(mem_req_ready),
		.mem_wdata_valid(mem_wdata_valid),
		.mem_wdata_ready(mem_wdata_ready),
		.refill_active(refill_active),
		.cpu_resp_valid(cpu_resp_valid),
		.store_ctl(store_ctl)
	);

	refill_counter u_refill_cnt (
		.clk(clk),
		.reset(reset),
		.refill_active(refill_active),
		.mem_resp_valid(mem_resp_valid),
		.beat(beat),
		.refill_last(refill_last)
	);

	cache_store u_store (
		.clk(clk),
		.reset(reset),
		.cpu_req(cpu_req),
		.store_ctl(store_ctl),
		.beat(beat),
		.mem_resp_data(mem_resp_data),
		.hit(hit),
		.req_write(req_write),
		.mem_req(mem_req),
		.mem_wdata(mem_wdata),
		.cpu_resp_data(cpu_resp_data)
	);

endmodule

/* cache/lane_align.sv */
`timescale 1ns/100ps
`include "cache_consts.svh"

module lane_align (
	input logic [`WORD_BITS-1:0] word,
	input logic [`CPU_DATA_BITS-1:0] wr_data,
	input logic [`CPU_MASK_BITS-1:0] wr_mask,
	input logic [`MEM_DATA_BITS-1:0] rd_beat,
	output logic [`CPU_DATA_BITS-1:0] rd_word,
	output logic [`MEM_DATA_BITS-1:0] lane_data,
	output logic [`MEM_MASK_BITS-1:0] lane_mask
);

	always_comb begin
		lane_data = '0;
		lane_mask = '0;
		case (word)
			2'd0: begin
				rd_word = rd_beat[31:0];
				lane_data[31:0] = wr_data;
				lane_mask[3:0] = wr_mask;
			end
			2'd1: begin
				rd_word = rd_beat[63:32];
				lane_data[63:32] = wr_data;
				lane_mask[7:4] = wr_mask;
			end
			2'd2: begin
				rd_word = rd_beat[95:64];
				lane_data[95:64] = wr_data;
				lane_mask[11:8] = wr_mask;
			end
			default: begin
				rd_word = rd_beat[127:96];
				lane_data[127:96] = wr_data;
				lane_mask[15:12] = wr_mask;
			end
		endcase
	end

endmodule

/* cache/refill_counter.sv */
`timescale 1ns/100ps
`include "cache_consts.svh"

module refill_counter (
	input logic clk,
	input logic reset,
	input logic refill_active,
	input logic mem_resp_valid,
	output logic [`BEAT_BITS-1:0] beat,
	output logic refill_last
);

	logic beat_in;

	assign beat_in = refill_active && mem_resp_valid;
	assign refill_last = beat_in && beat == `BEATS_PER_LINE - 1;

	// Wraps back to zero on the last beat
	always_ff @(posedge clk) begin
		if (reset) begin
			beat <= '0;
		end else if (beat_in) begin
			beat <= beat + 1'b1;
		end
	end

	resp_in_refill: assert property (@(posedge clk) disable iff (reset)
		mem_resp_valid |-> refill_active);

endmodule

/* common/cache_consts.svh */
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// CPU side, word addressed
`define CPU_ADDR_BITS 30
`define CPU_DATA_BITS 32
`define CPU_MASK_BITS 4

// Memory side, beat addressed
`define MEM_DATA_BITS 128
`define MEM_MASK_BITS 16
`define MEM_ADDR_BITS 28

// Address split
`define TAG_BITS 23
`define INDEX_BITS 3
`define BEAT_BITS 2
`define WORD_BITS 2

`define BEATS_PER_LINE 4

`endif

/* common/cache_pkg.sv */
`include "cache_consts.svh"

package cache_pkg;

	typedef struct packed {
		logic [`TAG_BITS-1:0] tag;
		logic [`INDEX_BITS-1:0] index;
		logic [`BEAT_BITS-1:0] beat;
		logic [`WORD_BITS-1:0] word;
	} cache_fields_t;

	typedef struct packed {
		logic [`CPU_ADDR_BITS-`WORD_BITS-1:0] beat_addr;
		logic [`WORD_BITS-1:0] word;
	} mem_fields_t;

	// Arrays use the cache view, the memory port the beat view
	typedef union packed {
		cache_fields_t cache;
		mem_fields_t mem;
	} cache_addr_t;

	// Zero wmask means read
	typedef struct packed {
		cache_addr_t addr;
		logic [`CPU_DATA_BITS-1:0] data;
		logic [`CPU_MASK_BITS-1:0] wmask;
	} cpu_req_t;

	typedef struct packed {
		logic [`MEM_ADDR_BITS-1:0] addr;
		logic rw;
	} mem_req_t;

	typedef struct packed {
		logic [`MEM_DATA_BITS-1:0] data;
		logic [`MEM_MASK_BITS-1:0] mask;
	} mem_wdata_t;

	typedef struct packed {
		logic accept;
		logic tag_fill;
		logic refill_beat;
		logic cpu_write;
		logic resp_refill;
	} store_ctl_t;

endpackage

/* flist.f */
+incdir+common
common/cache_pkg.sv
cache/lane_align.sv
cache/refill_counter.sv
cache/cache_store.sv
cache/cache_ctrl.sv
cache/cache_top.sv
bench/mem_model.sv
bench/cache_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then scan the log for the fail message
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module cache_tb -o cache_sim &&
./obj_dir/cache_sim > sim.log 2>&1 ||
{ cat sim.log; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
